//--- verilog/wb_bridge_config.svh
`ifndef WB_BRIDGE_CONFIG_SVH
`define WB_BRIDGE_CONFIG_SVH

// ------------------------------------------------------------
// bridge FIFO sizing
// ------------------------------------------------------------

// command path depth, master to target
`define WB_CMD_FIFO_DP 4

// response path only ever holds one blocking read
`define WB_RESP_FIFO_DP 2

// ------------------------------------------------------------
// register-file target window
// ------------------------------------------------------------

// number of 32-bit words in the target
`define WB_TGT_WORDS 16

// byte address of word 0
`define WB_TGT_BASE 32'h3000_0000

`endif

//--- verilog/wb_bridge_pkg.sv
package wb_bridge_pkg;

   // wishbone byte address
   typedef logic [31:0] wb_adr_t;

   // wishbone data word
   typedef logic [31:0] wb_data_t;

   // byte lane enables
   typedef logic [3:0] wb_sel_t;

   // command word {adr, we, dat, sel}
   typedef logic [68:0] wb_cmd_t;

   // response word {err, dat}
   typedef logic [32:0] wb_resp_t;

   // target handshake states
   typedef enum logic {
      TGT_IDLE,
      TGT_ACK
   } tgt_state_t;

endpackage

//--- verilog/async_fifo.sv
`timescale 1ns/1ns

module async_fifo #(
   parameter int W  = 32,
   parameter int DP = 4
) (
   // write side
   input  logic         wr_clk_i,
   input  logic         wr_rst_n_i,
   input  logic         wr_en_i,
   input  logic [W-1:0] wr_data_i,
   output logic         full_o,
   output logic         afull_o,
   // read side
   input  logic         rd_clk_i,
   input  logic         rd_rst_n_i,
   input  logic         rd_en_i,
   output logic         empty_o,
   output logic         aempty_o,
   output logic [W-1:0] rd_data_o
);

   // pointer carries one extra wrap bit
   localparam int AW = $clog2(DP);

   logic [W-1:0] mem [DP];

   logic [AW:0] wr_bin;
   logic [AW:0] wr_bin_nxt;
   logic [AW:0] wr_gray;
   logic [AW:0] rd_gray_s1;
   logic [AW:0] rd_gray_s2;
   logic [AW:0] wr_cnt;

   logic [AW:0] rd_bin;
   logic [AW:0] rd_bin_nxt;
   logic [AW:0] rd_gray;
   logic [AW:0] wr_gray_s1;
   logic [AW:0] wr_gray_s2;
   logic [AW:0] rd_cnt;

   function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
      return b ^ (b >> 1);
   endfunction

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // ------------------------------------------------------------
   // write clock domain
   // ------------------------------------------------------------

   // push only when there is room
   assign wr_bin_nxt = wr_bin + (AW+1)'(wr_en_i & ~full_o);
   // occupancy seen from the write side after this push
   assign wr_cnt     = wr_bin_nxt - gray2bin(rd_gray_s2);

   always_ff @(posedge wr_clk_i) begin
      if (wr_en_i && !full_o) begin
         mem[wr_bin[AW-1:0]] <= wr_data_i;
      end
   end

   always_ff @(posedge wr_clk_i) begin
      if (!wr_rst_n_i) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
         full_o     <= 1'b0;
         afull_o    <= 1'b0;
      end else begin
         wr_bin     <= wr_bin_nxt;
         wr_gray    <= bin2gray(wr_bin_nxt);
         // two-flop sync of the read pointer
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
         full_o     <= (wr_cnt == (AW+1)'(DP));
         // one slot left, or none
         afull_o    <= (wr_cnt >= (AW+1)'(DP - 1));
      end
   end

   // ------------------------------------------------------------
   // read clock domain
   // ------------------------------------------------------------

   assign rd_bin_nxt = rd_bin + (AW+1)'(rd_en_i & ~empty_o);
   assign rd_cnt     = gray2bin(wr_gray_s2) - rd_bin_nxt;

   // head word, valid while not empty
   assign rd_data_o = mem[rd_bin[AW-1:0]];

   always_ff @(posedge rd_clk_i) begin
      if (!rd_rst_n_i) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
         empty_o    <= 1'b1;
         aempty_o   <= 1'b1;
      end else begin
         rd_bin     <= rd_bin_nxt;
         rd_gray    <= bin2gray(rd_bin_nxt);
         // write pointer into read clock
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         empty_o    <= (rd_cnt == '0);
         // at most one word left
         aempty_o   <= (rd_cnt <= (AW+1)'(1));
      end
   end

endmodule

//--- verilog/async_wb.sv
`timescale 1ns/1ns
`include "wb_bridge_config.svh"

module async_wb import wb_bridge_pkg::*; (
   // master port
   input  logic     wbm_rst_n,
   input  logic     wbm_clk_i,
   input  logic     wbm_cyc_i,
   input  logic     wbm_stb_i,
   input  wb_adr_t  wbm_adr_i,
   input  logic     wbm_we_i,
   input  wb_data_t wbm_dat_i,
   input  wb_sel_t  wbm_sel_i,
   output wb_data_t wbm_dat_o,
   output logic     wbm_ack_o,
   output logic     wbm_err_o,
   // slave port
   input  logic     wbs_rst_n,
   input  logic     wbs_clk_i,
   output logic     wbs_cyc_o,
   output logic     wbs_stb_o,
   output wb_adr_t  wbs_adr_o,
   output logic     wbs_we_o,
   output wb_data_t wbs_dat_o,
   output wb_sel_t  wbs_sel_o,
   input  wb_data_t wbs_dat_i,
   input  logic     wbs_ack_i,
   input  logic     wbs_err_i
);

   // ------------------------------------------------------------
   // master clock domain
   // ------------------------------------------------------------

   logic     m_req;
   logic     pend_rd;
   logic     m_cmd_wr_en;
   wb_cmd_t  m_cmd_wr_data;
   logic     m_cmd_full;
   logic     m_cmd_afull;
   logic     m_rd_ack;
   logic     m_resp_empty;
   wb_resp_t m_resp_rd_data;

   assign m_req = wbm_cyc_i & wbm_stb_i;

   // accept while no read is in flight and the FIFO has two free slots
   assign m_cmd_wr_en   = m_req & ~pend_rd & ~m_cmd_full & ~m_cmd_afull;
   assign m_cmd_wr_data = {wbm_adr_i, wbm_we_i, wbm_dat_i, wbm_sel_i};

   // read completes when its response shows up
   assign m_rd_ack = m_req & ~wbm_we_i & pend_rd & ~m_resp_empty;

   // posted write acks on push
   assign wbm_ack_o = wbm_we_i ? m_cmd_wr_en : m_rd_ack;
   assign wbm_dat_o = m_resp_rd_data[31:0];
   assign wbm_err_o = m_resp_rd_data[32];

   // single outstanding read
   always_ff @(posedge wbm_clk_i) begin
      if (!wbm_rst_n) begin
         pend_rd <= 1'b0;
      end else if (m_cmd_wr_en && !wbm_we_i) begin
         pend_rd <= 1'b1;
      end else if (m_rd_ack) begin
         pend_rd <= 1'b0;
      end
   end

   // ------------------------------------------------------------
   // slave clock domain
   // ------------------------------------------------------------

   wb_cmd_t  s_cmd_rd_data;
   logic     s_cmd_empty;
   logic     s_resp_wr_en;
   wb_resp_t s_resp_wr_data;
   logic     s_resp_full;
   logic     wbs_ack_q;

   // ack delayed one cycle, used to drop stb between transfers
   always_ff @(posedge wbs_clk_i) begin
      if (!wbs_rst_n) begin
         wbs_ack_q <= 1'b0;
      end else begin
         wbs_ack_q <= wbs_ack_i;
      end
   end

   // fifo head drives the target
   assign {wbs_adr_o, wbs_we_o, wbs_dat_o, wbs_sel_o} = s_cmd_rd_data;
   assign wbs_stb_o = ~s_cmd_empty & ~wbs_ack_q;
   assign wbs_cyc_o = ~s_cmd_empty & ~wbs_ack_q;

   // reads only return a response
   assign s_resp_wr_en   = wbs_stb_o & ~wbs_we_o & wbs_ack_i & ~s_resp_full;
   assign s_resp_wr_data = {wbs_err_i, wbs_dat_i};

   async_fifo #(
      .W  ($bits(wb_cmd_t)),
      .DP (`WB_CMD_FIFO_DP)
   ) u_cmd_fifo (
      .wr_clk_i   (wbm_clk_i),
      .wr_rst_n_i (wbm_rst_n),
      .wr_en_i    (m_cmd_wr_en),
      .wr_data_i  (m_cmd_wr_data),
      .full_o     (m_cmd_full),
      .afull_o    (m_cmd_afull),
      .rd_clk_i   (wbs_clk_i),
      .rd_rst_n_i (wbs_rst_n),
      .rd_en_i    (wbs_ack_i),
      .empty_o    (s_cmd_empty),
      .aempty_o   (),
      .rd_data_o  (s_cmd_rd_data)
   );

   // blocking reads keep this one shallow
   async_fifo #(
      .W  ($bits(wb_resp_t)),
      .DP (`WB_RESP_FIFO_DP)
   ) u_resp_fifo (
      .wr_clk_i   (wbs_clk_i),
      .wr_rst_n_i (wbs_rst_n),
      .wr_en_i    (s_resp_wr_en),
      .wr_data_i  (s_resp_wr_data),
      .full_o     (s_resp_full),
      .afull_o    (),
      .rd_clk_i   (wbm_clk_i),
      .rd_rst_n_i (wbm_rst_n),
      .rd_en_i    (m_rd_ack),
      .empty_o    (m_resp_empty),
      .aempty_o   (),
      .rd_data_o  (m_resp_rd_data)
   );

endmodule

//--- verilog/wb_reg_target.sv
`timescale 1ns/1ns
`include "wb_bridge_config.svh"

module wb_reg_target import wb_bridge_pkg::*; (
   input  logic     wbs_clk_i,
   input  logic     wbs_rst_n,
   input  logic     wbs_cyc_i,
   input  logic     wbs_stb_i,
   input  wb_adr_t  wbs_adr_i,
   input  logic     wbs_we_i,
   input  wb_data_t wbs_dat_i,
   input  wb_sel_t  wbs_sel_i,
   output wb_data_t wbs_dat_o,
   output logic     wbs_ack_o,
   output logic     wbs_err_o
);

   localparam int      IDX_W    = $clog2(`WB_TGT_WORDS);
   localparam wb_adr_t TGT_BASE = `WB_TGT_BASE;
   localparam wb_adr_t TGT_END  = TGT_BASE + 4 * `WB_TGT_WORDS;

   tgt_state_t state;
   wb_data_t   regs [`WB_TGT_WORDS];
   wb_adr_t    offset;
   logic       hit;
   logic       take;
   logic [IDX_W-1:0] idx;

   // ------------------------------------------------------------
   // address decode
   // ------------------------------------------------------------

   assign offset = wbs_adr_i - TGT_BASE;
   // in window and word aligned
   assign hit    = (wbs_adr_i >= TGT_BASE) && (wbs_adr_i < TGT_END) &&
                   (wbs_adr_i[1:0] == 2'b00);
   assign idx    = offset[IDX_W+1:2];

   // new transfer seen while idle
   assign take = (state == TGT_IDLE) && wbs_cyc_i && wbs_stb_i;

   // ------------------------------------------------------------
   // handshake
   // ------------------------------------------------------------

   // one idle cycle, then ack
   always_ff @(posedge wbs_clk_i) begin
      if (!wbs_rst_n) begin
         state <= TGT_IDLE;
      end else begin
         case (state)
            TGT_IDLE: if (take) state <= TGT_ACK;
            TGT_ACK:  state <= TGT_IDLE;
            default:  state <= TGT_IDLE;
         endcase
      end
   end

   assign wbs_ack_o = (state == TGT_ACK);

   // read data and error held for the ack cycle
   always_ff @(posedge wbs_clk_i) begin
      if (take) begin
         wbs_dat_o <= hit ? regs[idx] : '0;
         wbs_err_o <= ~hit;
      end
   end

   // ------------------------------------------------------------
   // register file
   // ------------------------------------------------------------

   always_ff @(posedge wbs_clk_i) begin
      if (!wbs_rst_n) begin
         for (int i = 0; i < `WB_TGT_WORDS; i++) begin
            regs[i] <= '0;
         end
      end else if (take && wbs_we_i && hit) begin
         // selected lanes only
         for (int b = 0; b < 4; b++) begin
            if (wbs_sel_i[b]) begin
               regs[idx][8*b +: 8] <= wbs_dat_i[8*b +: 8];
            end
         end
      end
   end

endmodule

//--- verilog/wb_bridge_top.sv
`timescale 1ns/1ns

module wb_bridge_top import wb_bridge_pkg::*; (
   input  logic     wbm_rst_n,
   input  logic     wbm_clk_i,
   input  logic     wbs_rst_n,
   input  logic     wbs_clk_i,
   // master port
   input  logic     wbm_cyc_i,
   input  logic     wbm_stb_i,
   input  wb_adr_t  wbm_adr_i,
   input  logic     wbm_we_i,
   input  wb_data_t wbm_dat_i,
   input  wb_sel_t  wbm_sel_i,
   output wb_data_t wbm_dat_o,
   output logic     wbm_ack_o,
   output logic     wbm_err_o
);

   // internal slave bus in the target clock
   logic     wbs_cyc;
   logic     wbs_stb;
   wb_adr_t  wbs_adr;
   logic     wbs_we;
   wb_data_t wbs_wdat;
   wb_sel_t  wbs_sel;
   wb_data_t wbs_rdat;
   logic     wbs_ack;
   logic     wbs_err;

   async_wb u_async_wb (
      .wbm_rst_n (wbm_rst_n),
      .wbm_clk_i (wbm_clk_i),
      .wbm_cyc_i (wbm_cyc_i),
      .wbm_stb_i (wbm_stb_i),
      .wbm_adr_i (wbm_adr_i),
      .wbm_we_i  (wbm_we_i),
      .wbm_dat_i (wbm_dat_i),
      .wbm_sel_i (wbm_sel_i),
      .wbm_dat_o (wbm_dat_o),
      .wbm_ack_o (wbm_ack_o),
      .wbm_err_o (wbm_err_o),
      .wbs_rst_n (wbs_rst_n),
      .wbs_clk_i (wbs_clk_i),
      .wbs_cyc_o (wbs_cyc),
      .wbs_stb_o (wbs_stb),
      .wbs_adr_o (wbs_adr),
      .wbs_we_o  (wbs_we),
      .wbs_dat_o (wbs_wdat),
      .wbs_sel_o (wbs_sel),
      .wbs_dat_i (wbs_rdat),
      .wbs_ack_i (wbs_ack),
      .wbs_err_i (wbs_err)
   );

   // single register-file target
   wb_reg_target u_reg_target (
      .wbs_clk_i (wbs_clk_i),
      .wbs_rst_n (wbs_rst_n),
      .wbs_cyc_i (wbs_cyc),
      .wbs_stb_i (wbs_stb),
      .wbs_adr_i (wbs_adr),
      .wbs_we_i  (wbs_we),
      .wbs_dat_i (wbs_wdat),
      .wbs_sel_i (wbs_sel),
      .wbs_dat_o (wbs_rdat),
      .wbs_ack_o (wbs_ack),
      .wbs_err_o (wbs_err)
   );

endmodule

//--- tb/tb_wb_bridge.sv
`timescale 1ns/1ns
`include "wb_bridge_config.svh"

module tb_wb_bridge import wb_bridge_pkg::*; ();

   localparam int      TMO_CYCLES = 200;
   localparam wb_adr_t TGT_BASE   = `WB_TGT_BASE;

   logic     wbm_clk;
   logic     wbs_clk;
   logic     wbm_rst_n;
   logic     wbs_rst_n;
   logic     cyc;
   logic     stb;
   wb_adr_t  adr;
   logic     we;
   wb_data_t wdat;
   wb_sel_t  sel;
   wb_data_t rdat;
   logic     ack;
   logic     err;

   // reference copy of the register file
   wb_data_t    model [`WB_TGT_WORDS];
   logic [15:0] lfsr;
   int          errors;
   int          timeouts;

   wb_bridge_top i_wb_bridge_top (
      .wbm_rst_n (wbm_rst_n),
      .wbm_clk_i (wbm_clk),
      .wbs_rst_n (wbs_rst_n),
      .wbs_clk_i (wbs_clk),
      .wbm_cyc_i (cyc),
      .wbm_stb_i (stb),
      .wbm_adr_i (adr),
      .wbm_we_i  (we),
      .wbm_dat_i (wdat),
      .wbm_sel_i (sel),
      .wbm_dat_o (rdat),
      .wbm_ack_o (ack),
      .wbm_err_o (err)
   );

   // unrelated clocks of 20 ns and 26 ns
   initial begin
      wbm_clk = 1'b0;
      forever #10 wbm_clk = ~wbm_clk;
   end

   initial begin
      wbs_clk = 1'b0;
      forever #13 wbs_clk = ~wbs_clk;
   end

   // ------------------------------------------------------------
   // reference helpers
   // ------------------------------------------------------------

   // galois form with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   // inside the window and word aligned
   function automatic logic in_window(input wb_adr_t a);
      return (a >= TGT_BASE) && (a < TGT_BASE + 4 * `WB_TGT_WORDS) &&
             (a[1:0] == 2'b00);
   endfunction

   function automatic int word_idx(input wb_adr_t a);
      return int'((a - TGT_BASE) >> 2);
   endfunction

   // old word with the selected lanes replaced
   function automatic wb_data_t merge_lanes(input wb_data_t old_w, input wb_data_t new_w,
                                            input wb_sel_t s);
      wb_data_t m;
      m = old_w;
      for (int b = 0; b < 4; b++) begin
         if (s[b]) begin
            m[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return m;
   endfunction

   // one lfsr step per data bit
   task automatic rand_word(output wb_data_t w);
      for (int i = 0; i < 32; i++) begin
         lfsr = lfsr_step(lfsr);
         w[i] = lfsr[0];
      end
   endtask

   task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %0s data %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_err(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %0s err %b, expected %b", $time, what, got, exp);
      end
   endtask

   // ------------------------------------------------------------
   // master bus cycles
   // ------------------------------------------------------------

   // entered 2 ns after a rising edge and left at the same phase
   task automatic run_cycle(input logic w, input wb_adr_t a, input wb_data_t d,
                            input wb_sel_t s, output wb_data_t rd, output logic re,
                            output int waits, output logic done);
      done  = 1'b0;
      waits = 0;
      rd    = '0;
      re    = 1'b0;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = w;
      adr   = a;
      wdat  = d;
      sel   = s;
      // ack is combinational so look mid cycle
      while (!done && waits < TMO_CYCLES) begin
         @(negedge wbm_clk);
         if (ack) begin
            done = 1'b1;
            rd   = rdat;
            re   = err;
         end else begin
            waits++;
         end
      end
      @(posedge wbm_clk);
      #2;
      if (!done) begin
         timeouts++;
         $display("timeout: no acknowledge arrived within %0d cycles for the %0s at %h",
                  TMO_CYCLES, w ? "write" : "read", a);
      end
   endtask

   task automatic bus_idle();
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      @(posedge wbm_clk);
      #2;
   endtask

   task automatic do_write(input wb_adr_t a, input wb_data_t d, input wb_sel_t s);
      wb_data_t got_d;
      logic     got_e;
      int       waits;
      logic     done;
      run_cycle(1'b1, a, d, s, got_d, got_e, waits, done);
      // writes outside the window change nothing
      if (done && in_window(a)) begin
         model[word_idx(a)] = merge_lanes(model[word_idx(a)], d, s);
      end
   endtask

   // count consecutive words checked against the vector and the model
   task automatic do_read(input wb_adr_t a, input int count, input wb_data_t exp_d,
                          input logic exp_e);
      wb_adr_t  ra;
      wb_data_t got_d;
      logic     got_e;
      int       waits;
      logic     done;
      for (int k = 0; k < count; k++) begin
         ra = a + 4 * k;
         run_cycle(1'b0, ra, '0, 4'hf, got_d, got_e, waits, done);
         if (done) begin
            check_err(got_e, exp_e, "read");
            check_data(got_d, exp_d, "read");
            if (in_window(ra)) begin
               check_data(got_d, model[word_idx(ra)], "model");
            end
         end
      end
   endtask

   // back-to-back writes of random words and in-order readback
   task automatic do_burst(input wb_adr_t a, input int count, input wb_sel_t s);
      wb_adr_t  ra;
      wb_data_t d;
      wb_data_t got_d;
      logic     got_e;
      int       waits;
      int       stalls;
      logic     done;
      stalls = 0;
      for (int k = 0; k < count; k++) begin
         ra = a + 4 * k;
         rand_word(d);
         run_cycle(1'b1, ra, d, s, got_d, got_e, waits, done);
         stalls += waits;
         if (done && in_window(ra)) begin
            model[word_idx(ra)] = merge_lanes(model[word_idx(ra)], d, s);
         end
      end
      // more writes than the command FIFO holds must stall
      if (count > `WB_CMD_FIFO_DP && stalls == 0) begin
         errors++;
         $display("no back-pressure seen: all %0d back-to-back writes acked without a wait",
                  count);
      end
      for (int k = 0; k < count; k++) begin
         ra = a + 4 * k;
         run_cycle(1'b0, ra, '0, 4'hf, got_d, got_e, waits, done);
         if (done) begin
            check_err(got_e, !in_window(ra), "burst readback");
            check_data(got_d, in_window(ra) ? model[word_idx(ra)] : '0, "burst readback");
         end
      end
   endtask

   // ------------------------------------------------------------
   // vector loop
   // ------------------------------------------------------------

   initial begin
      int               fd;
      int               n;
      int               test_no;
      int               n_pass;
      int               n_fail;
      int               n_tmo;
      int               err_before;
      int               tmo_before;
      logic             open_bad;
      logic [8*128-1:0] line;
      logic [8*8-1:0]   op;
      wb_adr_t          f_adr;
      wb_data_t         f_dat;
      wb_sel_t          f_sel;
      wb_data_t         f_exp;
      logic             f_err;

      test_no  = 0;
      n_pass   = 0;
      n_fail   = 0;
      n_tmo    = 0;
      open_bad = 1'b0;
      errors   = 0;
      timeouts = 0;
      lfsr     = 16'd68;
      for (int i = 0; i < `WB_TGT_WORDS; i++) begin
         model[i] = '0;
      end
      cyc       = 1'b0;
      stb       = 1'b0;
      adr       = '0;
      we        = 1'b0;
      wdat      = '0;
      sel       = '0;
      wbm_rst_n = 1'b0;
      wbs_rst_n = 1'b0;

      // both domains held in reset for 4 master cycles
      repeat (4) @(posedge wbm_clk);
      #2;
      wbm_rst_n = 1'b1;
      wbs_rst_n = 1'b1;
      bus_idle();

      fd = $fopen("tb/wb_bridge_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file tb/wb_bridge_input.txt");
         open_bad = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
               n = $sscanf(line, "%s %h %h %h %h %h", op, f_adr, f_dat, f_sel, f_exp, f_err);
               // comment and blank lines fall through here
               if (n == 6 && (op == "write" || op == "read" || op == "burst")) begin
                  test_no++;
                  err_before = errors;
                  tmo_before = timeouts;
                  if (op == "write") begin
                     do_write(f_adr, f_dat, f_sel);
                  end else if (op == "read") begin
                     do_read(f_adr, int'(f_dat), f_exp, f_err);
                  end else begin
                     do_burst(f_adr, int'(f_dat), f_sel);
                  end
                  bus_idle();
                  if (timeouts != tmo_before) begin
                     n_tmo++;
                     $display("test %0d %0s %h: timeout", test_no, op, f_adr);
                  end else if (errors != err_before) begin
                     n_fail++;
                     $display("test %0d %0s %h: fail", test_no, op, f_adr);
                  end else begin
                     n_pass++;
                     $display("test %0d %0s %h: pass", test_no, op, f_adr);
                  end
               end
            end
         end
         $fclose(fd);
      end

      $display("tests passed %0d, failed %0d, timed out %0d", n_pass, n_fail, n_tmo);
      if (!open_bad && test_no > 0 && n_fail == 0 && n_tmo == 0 && errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- tb/wb_bridge_input.txt
# op    adr      dat      sel exp_dat  exp_err
# read: dat is a word count; burst: dat is a write count, data from the lfsr
read  30000000 00000010 f 00000000 0
write 30000004 a5a5a5a5 f 00000000 0
read  30000004 00000001 f a5a5a5a5 0
write 3000003c 12345678 f 00000000 0
read  3000003c 00000001 f 12345678 0
write 30000004 0000cc00 2 00000000 0
read  30000004 00000001 f a5a5cca5 0
write 30000008 11223344 f 00000000 0
write 30000008 aabbccdd 9 00000000 0
read  30000008 00000001 f aa2233dd 0
write 3000000c 55667788 6 00000000 0
read  3000000c 00000001 f 00667700 0
read  30000040 00000001 f 00000000 1
read  30000006 00000001 f 00000000 1
read  2ffffffc 00000001 f 00000000 1
write 30000005 ffffffff f 00000000 0
write 30000040 ffffffff f 00000000 0
read  30000004 00000001 f a5a5cca5 0
read  30000000 00000001 f 00000000 0
burst 30000020 00000008 f 00000000 0
burst 30000010 00000006 3 00000000 0

//--- wb_bridge_top.f
+incdir+verilog
verilog/wb_bridge_pkg.sv
verilog/async_fifo.sv
verilog/async_wb.sv
verilog/wb_reg_target.sv
verilog/wb_bridge_top.sv
tb/tb_wb_bridge.sv
